// ==== include/exec_settings.svh ====
// Width and iteration settings for the integer execute stage
// Data path, register index, sequence tag and multiplier step count

`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Data path width for pc, operands and results
`define EXEC_XLEN 32

// Architectural register index width
`define EXEC_RADDR_W 5

// Sequence number width, wraps modulo 2**EXEC_SEQ_W
`define EXEC_SEQ_W 5

// One multiplier iteration per operand bit
`define EXEC_MUL_STEPS `EXEC_XLEN

`endif

// ==== source/exec_pkg.sv ====
// Shared types of the execute stage
// Vector typedefs, micro-op codes and FSM state enums

`include "exec_settings.svh"

package exec_pkg;

  // ------------------------------
  // Vector types
  // ------------------------------

  // Pc, operands and write data
  typedef logic [`EXEC_XLEN-1:0]    word_t;

  // Age tag carried with every micro-op
  typedef logic [`EXEC_SEQ_W-1:0]   seq_t;

  // Architectural destination register
  typedef logic [`EXEC_RADDR_W-1:0] reg_addr_t;

  // ------------------------------
  // Micro-op codes
  // ------------------------------

  // Ten ALU ops plus the single multiply
  typedef enum logic [3:0] {
    UOP_ADD  = 4'd0,
    UOP_SUB  = 4'd1,
    UOP_AND  = 4'd2,
    UOP_OR   = 4'd3,
    UOP_XOR  = 4'd4,
    UOP_SLL  = 4'd5,
    UOP_SRL  = 4'd6,
    UOP_SRA  = 4'd7,
    UOP_SLT  = 4'd8,
    UOP_SLTU = 4'd9,
    UOP_MUL  = 4'd10
  } uop_t;

  // ------------------------------
  // State machines
  // ------------------------------

  // Iterative multiplier
  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_BUSY,
    MUL_DONE
  } mul_state_t;

  // Writeback grant lock
  typedef enum logic [1:0] {
    ARB_FREE,
    ARB_ALU,
    ARB_MUL
  } arb_state_t;

endpackage

// ==== source/alu_unit.sv ====
// Single-cycle integer ALU for the execute stage
// Ten arithmetic, logic, shift and compare micro-ops
// Result held in a one-entry output register under back-pressure

`timescale 1ns/1ps

`include "exec_settings.svh"

module alu_unit (
  input  logic               clk,
  input  logic               rst,

  // Dispatch side
  input  logic               in_val,
  output logic               in_rdy,
  input  exec_pkg::word_t     in_pc,
  input  exec_pkg::seq_t      in_seq,
  input  exec_pkg::word_t     in_op1,
  input  exec_pkg::word_t     in_op2,
  input  exec_pkg::reg_addr_t in_waddr,
  input  exec_pkg::uop_t      in_uop,

  // Result side
  output logic               out_val,
  input  logic               out_rdy,
  output exec_pkg::word_t     out_pc,
  output exec_pkg::seq_t      out_seq,
  output exec_pkg::reg_addr_t out_waddr,
  output exec_pkg::word_t     out_wdata
);

  import exec_pkg::*;

  // Shift amount width, 5 bits for a 32-bit data path
  localparam int SHAMT_W = $clog2(`EXEC_XLEN);

  logic               [SHAMT_W-1:0] shamt;
  word_t                            result;
  logic                             accept;

  // ------------------------------
  // Combinational datapath
  // ------------------------------

  // Only the low bits of op2 count for shifts
  assign shamt = in_op2[SHAMT_W-1:0];

  always_comb begin
    case (in_uop)
      UOP_ADD:  result = in_op1 + in_op2;
      UOP_SUB:  result = in_op1 - in_op2;
      UOP_AND:  result = in_op1 & in_op2;
      UOP_OR:   result = in_op1 | in_op2;
      UOP_XOR:  result = in_op1 ^ in_op2;
      UOP_SLL:  result = in_op1 << shamt;
      UOP_SRL:  result = in_op1 >> shamt;
      // Arithmetic shift keeps the sign
      UOP_SRA:  result = word_t'($signed(in_op1) >>> shamt);
      // Compares give 0 or 1
      UOP_SLT:  result = word_t'($signed(in_op1) < $signed(in_op2));
      UOP_SLTU: result = word_t'(in_op1 < in_op2);
      // Multiply never steered here
      default:  result = '0;
    endcase
  end

  // ------------------------------
  // Output register
  // ------------------------------

  // Free slot, or slot drained this cycle
  assign in_rdy = !out_val || out_rdy;
  assign accept = in_val && in_rdy;

  // Valid bit is control state
  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
    end else if (accept) begin
      out_val <= 1'b1;
    end else if (out_rdy) begin
      out_val <= 1'b0;
    end
  end

  // Payload only loads on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      out_pc    <= in_pc;
      out_seq   <= in_seq;
      out_waddr <= in_waddr;
      out_wdata <= result;
    end
  end

  // Stalled result must not change under the writeback
  a_wdata_stable: assert property (@(posedge clk) disable iff (rst)
    (out_val && !out_rdy) |=> (out_val && $stable(out_wdata)));

endmodule

// ==== source/mul_unit.sv ====
// Iterative shift-and-add multiplier
// Low half of the product, one partial product per cycle
// Small FSM holds the result until the writeback drains it

`timescale 1ns/1ps

`include "exec_settings.svh"

module mul_unit (
  input  logic               clk,
  input  logic               rst,

  // Dispatch side
  input  logic               in_val,
  output logic               in_rdy,
  input  exec_pkg::word_t     in_pc,
  input  exec_pkg::seq_t      in_seq,
  input  exec_pkg::word_t     in_op1,
  input  exec_pkg::word_t     in_op2,
  input  exec_pkg::reg_addr_t in_waddr,

  // Result side
  output logic               out_val,
  input  logic               out_rdy,
  output exec_pkg::word_t     out_pc,
  output exec_pkg::seq_t      out_seq,
  output exec_pkg::reg_addr_t out_waddr,
  output exec_pkg::word_t     out_wdata
);

  import exec_pkg::*;

  localparam int STEPS = `EXEC_MUL_STEPS;
  localparam int CNT_W = $clog2(STEPS);

  // Counter value of the final iteration
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(STEPS - 1);

  mul_state_t       state;
  logic [CNT_W-1:0] step;
  logic             accept;

  // Running product, shifted multiplicand, remaining multiplier bits
  word_t            acc;
  word_t            mcand;
  word_t            mplier;

  assign in_rdy    = (state == MUL_IDLE);
  assign out_val   = (state == MUL_DONE);
  assign accept    = in_val && in_rdy;
  assign out_wdata = acc;

  // ------------------------------
  // Control FSM
  // ------------------------------

  // Step 0 happens on accept, the rest in MUL_BUSY
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= MUL_IDLE;
      step  <= '0;
    end else begin
      case (state)
        MUL_IDLE: begin
          if (accept) begin
            state <= MUL_BUSY;
            step  <= CNT_W'(1);
          end
        end
        MUL_BUSY: begin
          step <= step + CNT_W'(1);
          if (step == LAST_STEP) begin
            state <= MUL_DONE;
          end
        end
        MUL_DONE: begin
          if (out_rdy) begin
            state <= MUL_IDLE;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      out_pc    <= in_pc;
      out_seq   <= in_seq;
      out_waddr <= in_waddr;
      // First partial product straight from the operands
      acc       <= in_op2[0] ? in_op1 : '0;
      mcand     <= in_op1 << 1;
      mplier    <= in_op2 >> 1;
    end else if (state == MUL_BUSY) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Accept only from idle, so the tags hold outside it
  a_accept_idle: assert property (@(posedge clk) disable iff (rst)
    (state != MUL_IDLE) |=>
      ($stable(out_pc) && $stable(out_seq) && $stable(out_waddr)));

  // Result shows up exactly STEPS cycles after accept
  a_latency: assert property (@(posedge clk) disable iff (rst)
    (in_val && in_rdy) |=> (!out_val [*STEPS-1] ##1 out_val));

endmodule

// ==== source/exec_ctrl.sv ====
// Execute stage control
// Dispatch steering between the ALU and the multiplier
// Oldest-first writeback arbitration with a grant lock and wen

`timescale 1ns/1ps

module exec_ctrl (
  input  logic               clk,
  input  logic               rst,

  // Dispatch from decode
  input  logic               d_val,
  output logic               d_rdy,
  input  exec_pkg::uop_t      d_uop,

  // Unit dispatch handshakes
  output logic               alu_in_val,
  input  logic               alu_in_rdy,
  output logic               mul_in_val,
  input  logic               mul_in_rdy,

  // ALU result
  input  logic               alu_out_val,
  output logic               alu_out_rdy,
  input  exec_pkg::word_t     alu_out_pc,
  input  exec_pkg::seq_t      alu_out_seq,
  input  exec_pkg::reg_addr_t alu_out_waddr,
  input  exec_pkg::word_t     alu_out_wdata,

  // Multiplier result
  input  logic               mul_out_val,
  output logic               mul_out_rdy,
  input  exec_pkg::word_t     mul_out_pc,
  input  exec_pkg::seq_t      mul_out_seq,
  input  exec_pkg::reg_addr_t mul_out_waddr,
  input  exec_pkg::word_t     mul_out_wdata,

  // Writeback
  output logic               w_val,
  input  logic               w_rdy,
  output exec_pkg::word_t     w_pc,
  output exec_pkg::seq_t      w_seq,
  output exec_pkg::reg_addr_t w_waddr,
  output exec_pkg::word_t     w_wdata,
  output logic               w_wen
);

  import exec_pkg::*;

  logic       is_mul;
  seq_t       seq_diff;
  logic       alu_older;
  logic       sel_alu;
  logic       sel_mul;
  arb_state_t arb_state;
  arb_state_t arb_next;

  // ------------------------------
  // Dispatch steering
  // ------------------------------

  assign is_mul     = (d_uop == UOP_MUL);
  assign alu_in_val = d_val && !is_mul;
  assign mul_in_val = d_val && is_mul;
  // Ready of the unit this op class goes to
  assign d_rdy      = is_mul ? mul_in_rdy : alu_in_rdy;

  // ------------------------------
  // Writeback arbitration
  // ------------------------------

  // Wrapped age compare, top bit clear means ALU result is older
  assign seq_diff  = mul_out_seq - alu_out_seq;
  assign alu_older = !seq_diff[$bits(seq_t)-1];

  always_comb begin
    sel_alu = 1'b0;
    sel_mul = 1'b0;
    case (arb_state)
      ARB_ALU: sel_alu = 1'b1;
      ARB_MUL: sel_mul = 1'b1;
      default: begin
        // Both valid goes by age
        if (alu_out_val && mul_out_val) begin
          sel_alu = alu_older;
          sel_mul = !alu_older;
        end else begin
          sel_alu = alu_out_val;
          sel_mul = mul_out_val;
        end
      end
    endcase
  end

  // Zero-cycle path from unit valids to W
  assign w_val       = (sel_alu && alu_out_val) || (sel_mul && mul_out_val);
  assign alu_out_rdy = sel_alu && w_rdy;
  assign mul_out_rdy = sel_mul && w_rdy;

  // Lock the grant while W stalls, release on transfer
  always_comb begin
    arb_next = ARB_FREE;
    if (w_val && !w_rdy) begin
      arb_next = sel_alu ? ARB_ALU : ARB_MUL;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      arb_state <= ARB_FREE;
    end else begin
      arb_state <= arb_next;
    end
  end

  // ------------------------------
  // Writeback payload
  // ------------------------------

  assign w_pc    = sel_mul ? mul_out_pc    : alu_out_pc;
  assign w_seq   = sel_mul ? mul_out_seq   : alu_out_seq;
  assign w_waddr = sel_mul ? mul_out_waddr : alu_out_waddr;
  assign w_wdata = sel_mul ? mul_out_wdata : alu_out_wdata;
  // x0 writes are dropped
  assign w_wen   = (w_waddr != '0);

  // One unit drained per cycle at most
  a_one_drain: assert property (@(posedge clk) disable iff (rst)
    !(alu_out_rdy && mul_out_rdy));

  // Stalled W payload holds even if an older result arrives
  a_w_stable: assert property (@(posedge clk) disable iff (rst)
    (w_val && !w_rdy) |=>
      (w_val && $stable({w_pc, w_seq, w_waddr, w_wdata, w_wen})));

endmodule

// ==== source/exec_top.sv ====
// Integer execute stage top level
// Control, single-cycle ALU and iterative multiplier

`timescale 1ns/1ps

module exec_top (
  input  logic               clk,
  input  logic               rst,

  // Decode side
  input  logic               d_val,
  output logic               d_rdy,
  input  exec_pkg::word_t     d_pc,
  input  exec_pkg::seq_t      d_seq,
  input  exec_pkg::word_t     d_op1,
  input  exec_pkg::word_t     d_op2,
  input  exec_pkg::reg_addr_t d_waddr,
  input  exec_pkg::uop_t      d_uop,

  // Writeback side
  output logic               w_val,
  input  logic               w_rdy,
  output exec_pkg::word_t     w_pc,
  output exec_pkg::seq_t      w_seq,
  output exec_pkg::reg_addr_t w_waddr,
  output exec_pkg::word_t     w_wdata,
  output logic               w_wen
);

  import exec_pkg::*;

  // Dispatch handshakes
  logic      alu_in_val;
  logic      alu_in_rdy;
  logic      mul_in_val;
  logic      mul_in_rdy;

  // ALU result path
  logic      alu_out_val;
  logic      alu_out_rdy;
  word_t     alu_out_pc;
  seq_t      alu_out_seq;
  reg_addr_t alu_out_waddr;
  word_t     alu_out_wdata;

  // Multiplier result path
  logic      mul_out_val;
  logic      mul_out_rdy;
  word_t     mul_out_pc;
  seq_t      mul_out_seq;
  reg_addr_t mul_out_waddr;
  word_t     mul_out_wdata;

  exec_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .d_val         (d_val),
    .d_rdy         (d_rdy),
    .d_uop         (d_uop),
    .alu_in_val    (alu_in_val),
    .alu_in_rdy    (alu_in_rdy),
    .mul_in_val    (mul_in_val),
    .mul_in_rdy    (mul_in_rdy),
    .alu_out_val   (alu_out_val),
    .alu_out_rdy   (alu_out_rdy),
    .alu_out_pc    (alu_out_pc),
    .alu_out_seq   (alu_out_seq),
    .alu_out_waddr (alu_out_waddr),
    .alu_out_wdata (alu_out_wdata),
    .mul_out_val   (mul_out_val),
    .mul_out_rdy   (mul_out_rdy),
    .mul_out_pc    (mul_out_pc),
    .mul_out_seq   (mul_out_seq),
    .mul_out_waddr (mul_out_waddr),
    .mul_out_wdata (mul_out_wdata),
    .w_val         (w_val),
    .w_rdy         (w_rdy),
    .w_pc          (w_pc),
    .w_seq         (w_seq),
    .w_waddr       (w_waddr),
    .w_wdata       (w_wdata),
    .w_wen         (w_wen)
  );

  // Payload fans out to both units
  alu_unit u_alu (
    .clk       (clk),
    .rst       (rst),
    .in_val    (alu_in_val),
    .in_rdy    (alu_in_rdy),
    .in_pc     (d_pc),
    .in_seq    (d_seq),
    .in_op1    (d_op1),
    .in_op2    (d_op2),
    .in_waddr  (d_waddr),
    .in_uop    (d_uop),
    .out_val   (alu_out_val),
    .out_rdy   (alu_out_rdy),
    .out_pc    (alu_out_pc),
    .out_seq   (alu_out_seq),
    .out_waddr (alu_out_waddr),
    .out_wdata (alu_out_wdata)
  );

  mul_unit u_mul (
    .clk       (clk),
    .rst       (rst),
    .in_val    (mul_in_val),
    .in_rdy    (mul_in_rdy),
    .in_pc     (d_pc),
    .in_seq    (d_seq),
    .in_op1    (d_op1),
    .in_op2    (d_op2),
    .in_waddr  (d_waddr),
    .out_val   (mul_out_val),
    .out_rdy   (mul_out_rdy),
    .out_pc    (mul_out_pc),
    .out_seq   (mul_out_seq),
    .out_waddr (mul_out_waddr),
    .out_wdata (mul_out_wdata)
  );

endmodule

// ==== bench/exec_tb.sv ====
// Testbench for the integer execute stage
// Seeded random stimulus on the D port, reference model by sequence number
// Scoreboard and stall checks on the W port

`timescale 1ns/1ps

`include "exec_settings.svh"

module exec_tb;

  import exec_pkg::*;

  localparam int STEPS   = `EXEC_MUL_STEPS;
  localparam int NTAG    = 1 << `EXEC_SEQ_W;
  localparam int TIMEOUT = 500;

  logic      clk;
  logic      rst;
  logic      d_val;
  logic      d_rdy;
  word_t     d_pc;
  seq_t      d_seq;
  word_t     d_op1;
  word_t     d_op2;
  reg_addr_t d_waddr;
  uop_t      d_uop;
  logic      w_val;
  logic      w_rdy;
  word_t     w_pc;
  seq_t      w_seq;
  reg_addr_t w_waddr;
  word_t     w_wdata;
  logic      w_wen;

  integer    seed;
  integer    rdy_seed;
  logic      rdy_random;
  logic      check_lat;
  seq_t      next_seq;
  int        cycle;
  int        pending;
  int        issued;
  int        received;
  int        errors;
  int        checks;
  int        tests_ok;
  int        tests_bad;

  // Model results indexed by sequence number
  word_t     exp_wdata [NTAG];
  word_t     exp_pc [NTAG];
  reg_addr_t exp_waddr [NTAG];
  logic      busy_tag [NTAG];
  int        exp_lat [NTAG];
  int        issue_cycle [NTAG];
  int        rx_order [NTAG];

  // Last W payload seen while stalled
  logic      stalled;
  word_t     hold_pc;
  seq_t      hold_seq;
  reg_addr_t hold_waddr;
  word_t     hold_wdata;
  logic      hold_wen;

  exec_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .d_val   (d_val),
    .d_rdy   (d_rdy),
    .d_pc    (d_pc),
    .d_seq   (d_seq),
    .d_op1   (d_op1),
    .d_op2   (d_op2),
    .d_waddr (d_waddr),
    .d_uop   (d_uop),
    .w_val   (w_val),
    .w_rdy   (w_rdy),
    .w_pc    (w_pc),
    .w_seq   (w_seq),
    .w_waddr (w_waddr),
    .w_wdata (w_wdata),
    .w_wen   (w_wen)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // Reference model
  // ------------------------------

  // RISC-V semantics, low half of the product for MUL
  function automatic word_t model_result(input uop_t uop, input word_t a, input word_t b);
    logic [2*`EXEC_XLEN-1:0] prod;
    word_t                   res;
    word_t                   sign;
    int                      sh;
    int                      i;
    sign = word_t'(1) << (`EXEC_XLEN - 1);
    sh   = b % `EXEC_XLEN;
    case (uop)
      UOP_ADD:  res = a + b;
      UOP_SUB:  res = a + ~b + word_t'(1);
      UOP_AND:  res = a & b;
      UOP_OR:   res = a | b;
      UOP_XOR:  res = a ^ b;
      UOP_SLL:  res = a << sh;
      UOP_SRL:  res = a >> sh;
      UOP_SRA: begin
        res = a >> sh;
        // Refill vacated top bits with the sign
        for (i = 0; i < sh; i++) begin
          res[`EXEC_XLEN-1-i] = a[`EXEC_XLEN-1];
        end
      end
      // Signed compare as unsigned with the sign bits flipped
      UOP_SLT:  res = ((a ^ sign) < (b ^ sign)) ? word_t'(1) : '0;
      UOP_SLTU: res = (a < b) ? word_t'(1) : '0;
      default: begin
        prod = {{`EXEC_XLEN{1'b0}}, a} * {{`EXEC_XLEN{1'b0}}, b};
        res  = prod[`EXEC_XLEN-1:0];
      end
    endcase
    return res;
  endfunction

  // Edge operands mixed in with plain random ones
  function word_t rand_operand();
    case ({$random(seed)} % 6)
      0:       return '0;
      1:       return '1;
      2:       return word_t'(1) << (`EXEC_XLEN - 1);
      3:       return word_t'(31);
      default: return $random(seed);
    endcase
  endfunction

  // ------------------------------
  // Checks and reporting
  // ------------------------------

  task automatic check_value(input string name, input word_t exp, input word_t act);
    checks++;
    assert (exp === act) else begin
      $display("error %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out while waiting for %s", what);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------

  // One D transfer, at most two results outstanding
  task automatic issue(input uop_t uop, input word_t a, input word_t b,
                       input reg_addr_t waddr);
    int t;
    @(negedge clk);
    d_val = 1'b0;
    t = 0;
    while (pending >= 2) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) stop_on_timeout("a free issue slot");
    end
    d_val   = 1'b1;
    d_pc    = $random(seed) & ~word_t'(3);
    d_seq   = next_seq;
    d_op1   = a;
    d_op2   = b;
    d_waddr = waddr;
    d_uop   = uop;
    exp_wdata[next_seq] = model_result(uop, a, b);
    exp_pc[next_seq]    = d_pc;
    exp_waddr[next_seq] = waddr;
    busy_tag[next_seq]  = 1'b1;
    exp_lat[next_seq]   = !check_lat ? 0 : (uop == UOP_MUL) ? STEPS : 1;
    pending++;
    issued++;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) stop_on_timeout("d_rdy");
    end while (!(d_val && d_rdy));
    next_seq++;
  endtask

  task automatic drain();
    int t;
    @(negedge clk);
    d_val = 1'b0;
    t = 0;
    while (pending != 0) begin
      @(negedge clk);
      t++;
      if (t > 4 * TIMEOUT) stop_on_timeout("outstanding results on W");
    end
  endtask

  // W back-pressure, random only in the stress test
  always @(negedge clk) begin
    if (rdy_random) begin
      w_rdy = ($random(rdy_seed) & 1) != 0;
    end else begin
      w_rdy = 1'b1;
    end
  end

  // ------------------------------
  // W monitor and scoreboard
  // ------------------------------

  always @(posedge clk) begin
    cycle++;
    if (rst) begin
      stalled = 1'b0;
    end else begin
      if (d_val && d_rdy) begin
        issue_cycle[d_seq] = cycle;
      end
      // Stalled payload must hold until the transfer
      if (stalled) begin
        check_true(w_val, "w_val dropped before its transfer");
        check_value("w_pc", hold_pc, w_pc);
        check_value("w_seq", word_t'(hold_seq), word_t'(w_seq));
        check_value("w_waddr", word_t'(hold_waddr), word_t'(w_waddr));
        check_value("w_wdata", hold_wdata, w_wdata);
        check_value("w_wen", word_t'(hold_wen), word_t'(w_wen));
      end
      if (w_val && w_rdy) begin
        check_true(busy_tag[w_seq],
                   $sformatf("sequence number %0d came out but was not outstanding", w_seq));
        if (busy_tag[w_seq]) begin
          check_value("w_pc", exp_pc[w_seq], w_pc);
          check_value("w_waddr", word_t'(exp_waddr[w_seq]), word_t'(w_waddr));
          check_value("w_wdata", exp_wdata[w_seq], w_wdata);
          check_value("w_wen", word_t'(exp_waddr[w_seq] != '0), word_t'(w_wen));
          if (exp_lat[w_seq] != 0) begin
            check_true(cycle - issue_cycle[w_seq] == exp_lat[w_seq],
                       $sformatf("sequence number %0d took %0d cycles instead of %0d",
                                 w_seq, cycle - issue_cycle[w_seq], exp_lat[w_seq]));
          end
          busy_tag[w_seq] = 1'b0;
          rx_order[w_seq] = received;
          pending--;
        end
        // Every W transfer counts, expected or not
        received++;
      end
      stalled    = w_val && !w_rdy;
      hold_pc    = w_pc;
      hold_seq   = w_seq;
      hold_waddr = w_waddr;
      hold_wdata = w_wdata;
      hold_wen   = w_wen;
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    int   err_before;
    int   i;
    int   k;
    seq_t mul_tag;
    seq_t alu_tag;
    seed       = 11046;
    rdy_seed   = $random(seed);
    rst        = 1'b1;
    d_val      = 1'b0;
    d_pc       = '0;
    d_seq      = '0;
    d_op1      = '0;
    d_op2      = '0;
    d_waddr    = '0;
    d_uop      = UOP_ADD;
    w_rdy      = 1'b1;
    rdy_random = 1'b0;
    check_lat  = 1'b1;
    next_seq   = '0;
    cycle      = 0;
    pending    = 0;
    issued     = 0;
    received   = 0;
    errors     = 0;
    checks     = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    stalled    = 1'b0;
    for (i = 0; i < NTAG; i++) begin
      busy_tag[i] = 1'b0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle state straight out of reset
    err_before = errors;
    check_true(w_val === 1'b0, "w_val is not low after reset");
    check_true(d_rdy === 1'b1, "d_rdy is not high after reset");
    finish_test("reset state", err_before);

    // Every ALU kind first, then random kinds
    err_before = errors;
    for (i = 0; i < 60; i++) begin
      k = (i < 10) ? i : {$random(seed)} % 10;
      issue(uop_t'(k), rand_operand(), rand_operand(), reg_addr_t'($random(seed)));
    end
    drain();
    finish_test("alu ops", err_before);

    err_before = errors;
    for (i = 0; i < 8; i++) begin
      issue(UOP_MUL, rand_operand(), rand_operand(), reg_addr_t'($random(seed)));
    end
    drain();
    finish_test("multiply", err_before);

    // Half of the ops target x0
    err_before = errors;
    check_lat  = 1'b0;
    for (i = 0; i < 40; i++) begin
      k = {$random(seed)} % 11;
      issue(uop_t'(k), rand_operand(), rand_operand(),
            ($random(seed) & 1) ? reg_addr_t'(0) : reg_addr_t'($random(seed)));
    end
    drain();
    finish_test("write enable", err_before);

    // Younger ALU op overtakes the multiply
    err_before = errors;
    check_lat  = 1'b1;
    for (i = 0; i < 4; i++) begin
      mul_tag = next_seq;
      issue(UOP_MUL, rand_operand(), rand_operand(), reg_addr_t'($random(seed)));
      alu_tag = next_seq;
      issue(uop_t'({$random(seed)} % 10), rand_operand(), rand_operand(),
            reg_addr_t'($random(seed)));
      drain();
      check_true(rx_order[alu_tag] < rx_order[mul_tag],
                 "ALU result did not leave before the older multiply");
    end
    finish_test("alu overtakes multiply", err_before);

    // Mixed stream under random back-pressure
    err_before = errors;
    check_lat  = 1'b0;
    rdy_random = 1'b1;
    for (i = 0; i < 150; i++) begin
      k = {$random(seed)} % 11;
      issue(uop_t'(k), rand_operand(), rand_operand(), reg_addr_t'($random(seed)));
    end
    drain();
    rdy_random = 1'b0;
    check_true(received == issued,
               $sformatf("issued %0d ops but received %0d results", issued, received));
    finish_test("back-pressure stream", err_before);

    $display("tests passed %0d failed %0d, checks %0d, errors %0d",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
source/exec_pkg.sv
source/alu_unit.sv
source/mul_unit.sv
source/exec_ctrl.sv
source/exec_top.sv
bench/exec_tb.sv

// ==== Bender.yml ====
package:
  name: exec_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/exec_pkg.sv
      - source/alu_unit.sv
      - source/mul_unit.sv
      - source/exec_ctrl.sv
      - source/exec_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/exec_tb.sv
